/* Makefile */
# Verilator build and run of the CSR unit testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module csr_unit_tb -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "FAIL: run incomplete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* list.f */
logic/csr_pkg.sv
logic/priv_pkg.sv
logic/machine_status.sv
logic/machine_csr_file.sv
logic/trap_control.sv
logic/csr_unit.sv
sim/csr_unit_properties.sv
sim/csr_unit_tb.sv

/* logic/csr_pkg.sv */
// CSR map, register field positions and access structs
// shared by the machine-mode CSR unit
package csr_pkg;

  localparam int xlen = 32;

  typedef logic [11:0] csr_addr_t;
  typedef logic [xlen-1:0] csr_data_t;

  // Machine CSR numbers kept in this unit
  typedef enum logic [11:0] {
    csr_mstatus  = 12'h300,
    csr_misa     = 12'h301,
    csr_mie      = 12'h304,
    csr_mtvec    = 12'h305,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mtval    = 12'h343,
    csr_mip      = 12'h344
  } csr_addr_e;

  // MXL of 1, I and U extensions
  localparam csr_data_t misa_value = 32'h4010_0100;

  // mstatus fields, MPP is two bits wide
  localparam int status_mie  = 3;
  localparam int status_mpie = 7;
  localparam int status_mpp  = 11;

  // Same positions in mie and mip
  localparam int msi_bit = 3;
  localparam int mti_bit = 7;
  localparam int mei_bit = 11;

  // Raw access from the core
  typedef struct packed {
    logic      wr_en;
    csr_addr_t addr;
    csr_data_t wr_data;
  } csr_access_t;

  // Write left over after trap and mret masking
  typedef struct packed {
    logic      wr_en;
    csr_addr_t addr;
    csr_data_t wr_data;
  } csr_write_t;

  typedef struct packed {
    logic       mie;
    logic       mpie;
    logic [1:0] mpp;
  } status_t;

  // Enables or pending lines of the machine interrupts
  typedef struct packed {
    logic external;
    logic timer;
    logic software;
  } irq_t;

endpackage

/* logic/csr_unit.sv */
`timescale 1ns/1ps
// Machine-mode CSR unit for a 32-bit RISC-V core with user and machine
// privilege levels
module csr_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  csr_pkg::csr_access_t access,
  input  logic                 mret,
  input  logic                 illegal_instruction,
  input  logic                 ecall,
  input  csr_pkg::csr_data_t   pc,
  input  logic [31:0]          instruction,
  input  logic                 external_interrupt,
  input  logic                 mem_msip,
  input  logic [63:0]          mem_mtime,
  input  logic [63:0]          mem_mtimecmp,
  output csr_pkg::csr_data_t   rd_data,
  output logic                 addr_exception,
  output csr_pkg::csr_data_t   mepc,
  output csr_pkg::csr_data_t   trap_addr,
  output logic                 trap,
  output priv_pkg::priv_e      privilege_mode
);
  import csr_pkg::*;
  import priv_pkg::*;

  csr_write_t write;
  status_t    status;
  irq_t       enable;
  irq_t       pending;
  csr_data_t  mtvec;
  trap_req_t  trap_req;

  machine_status i_status (
    .clock    (clock),
    .reset    (reset),
    .access   (access),
    .mret     (mret),
    .trap_req (trap_req),
    .write    (write),
    .status   (status),
    .priv     (privilege_mode)
  );

  machine_csr_file i_csr_file (
    .clock              (clock),
    .reset              (reset),
    .access             (access),
    .write              (write),
    .status             (status),
    .trap_req           (trap_req),
    .pc                 (pc),
    .instruction        (instruction),
    .external_interrupt (external_interrupt),
    .mem_msip           (mem_msip),
    .mem_mtime          (mem_mtime),
    .mem_mtimecmp       (mem_mtimecmp),
    .rd_data            (rd_data),
    .addr_exception     (addr_exception),
    .enable             (enable),
    .pending            (pending),
    .mtvec              (mtvec),
    .mepc               (mepc)
  );

  trap_control i_trap (
    .enable              (enable),
    .pending             (pending),
    .status              (status),
    .priv                (privilege_mode),
    .mtvec               (mtvec),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .trap_req            (trap_req),
    .trap                (trap),
    .trap_addr           (trap_addr)
  );

endmodule

/* logic/machine_csr_file.sv */
`timescale 1ns/1ps
// Machine CSR storage with the WARL write rules,
// trap capture of mepc, mcause and mtval, and the read multiplexer
module machine_csr_file (
  input  logic                 clock,
  input  logic                 reset,
  input  csr_pkg::csr_access_t access,
  input  csr_pkg::csr_write_t  write,
  input  csr_pkg::status_t     status,
  input  priv_pkg::trap_req_t  trap_req,
  input  csr_pkg::csr_data_t   pc,
  input  logic [31:0]          instruction,
  input  logic                 external_interrupt,
  input  logic                 mem_msip,
  input  logic [63:0]          mem_mtime,
  input  logic [63:0]          mem_mtimecmp,
  output csr_pkg::csr_data_t   rd_data,
  output logic                 addr_exception,
  output csr_pkg::irq_t        enable,
  output csr_pkg::irq_t        pending,
  output csr_pkg::csr_data_t   mtvec,
  output csr_pkg::csr_data_t   mepc
);
  import csr_pkg::*;
  import priv_pkg::*;

  csr_data_t mscratch;
  csr_data_t mcause;
  csr_data_t mtval;
  csr_data_t mstatus_value;
  csr_data_t trap_cause;

  logic wr_mtvec;
  logic wr_mie;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;

  // mcause is WLRL, only codes this unit can raise are accepted
  function automatic logic legal_cause(csr_data_t value);
    logic [xlen-2:0] code;
    code = value[xlen-2:0];
    if (value[xlen-1]) begin
      return code == cause_msi || code == cause_mti || code == cause_mei;
    end
    return code == cause_illegal_instr || code == cause_ecall_u || code == cause_ecall_m;
  endfunction

  // Place the three interrupt bits at their mie/mip positions
  function automatic csr_data_t irq_to_csr(irq_t irq);
    csr_data_t value;
    value          = '0;
    value[msi_bit] = irq.software;
    value[mti_bit] = irq.timer;
    value[mei_bit] = irq.external;
    return value;
  endfunction

  assign wr_mtvec    = write.wr_en && (write.addr == csr_mtvec);
  assign wr_mie      = write.wr_en && (write.addr == csr_mie);
  assign wr_mscratch = write.wr_en && (write.addr == csr_mscratch);
  assign wr_mepc     = write.wr_en && (write.addr == csr_mepc);
  assign wr_mcause   = write.wr_en && (write.addr == csr_mcause);
  assign wr_mtval    = write.wr_en && (write.addr == csr_mtval);

  // mip is read-only, driven by the interrupt lines and the timer compare
  assign pending = '{
    external: external_interrupt,
    timer:    (mem_mtime >= mem_mtimecmp),
    software: mem_msip
  };

  assign trap_cause = {trap_req.interrupt, {(xlen - 6){1'b0}}, trap_req.code};

  // Registers only written through the CSR port
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec    <= '0;
      enable   <= '0;
      mscratch <= '0;
    end else begin
      // Bit 1 of mtvec is reserved and reads 0
      if (wr_mtvec) begin
        mtvec <= {write.wr_data[xlen-1:2], 1'b0, write.wr_data[0]};
      end
      if (wr_mie) begin
        enable.external <= write.wr_data[mei_bit];
        enable.timer    <= write.wr_data[mti_bit];
        enable.software <= write.wr_data[msi_bit];
      end
      if (wr_mscratch) begin
        mscratch <= write.wr_data;
      end
    end
  end

  // Registers also loaded on trap entry
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap_req.take) begin
      mepc   <= pc;
      mcause <= trap_cause;
      if (trap_req.capture_tval) begin
        mtval <= instruction;
      end
    end else begin
      if (wr_mepc) begin
        mepc <= {write.wr_data[xlen-1:2], 2'b00};
      end
      if (wr_mcause && legal_cause(write.wr_data)) begin
        mcause <= write.wr_data;
      end
      if (wr_mtval) begin
        mtval <= write.wr_data;
      end
    end
  end

  always_comb begin
    mstatus_value                      = '0;
    mstatus_value[status_mie]          = status.mie;
    mstatus_value[status_mpie]         = status.mpie;
    mstatus_value[status_mpp +: 2]     = status.mpp;
  end

  // Reads decode the raw address so they work while a write is masked
  always_comb begin
    rd_data        = '0;
    addr_exception = 1'b0;
    case (access.addr)
      csr_mstatus:  rd_data = mstatus_value;
      csr_misa:     rd_data = misa_value;
      csr_mie:      rd_data = irq_to_csr(enable);
      csr_mtvec:    rd_data = mtvec;
      csr_mscratch: rd_data = mscratch;
      csr_mepc:     rd_data = mepc;
      csr_mcause:   rd_data = mcause;
      csr_mtval:    rd_data = mtval;
      csr_mip:      rd_data = irq_to_csr(pending);
      default:      addr_exception = 1'b1;
    endcase
  end

endmodule

/* logic/machine_status.sv */
`timescale 1ns/1ps
// Privilege register and mstatus fields
// Orders trap entry, mret and CSR writes and produces the masked write
module machine_status (
  input  logic                 clock,
  input  logic                 reset,
  input  csr_pkg::csr_access_t access,
  input  logic                 mret,
  input  priv_pkg::trap_req_t  trap_req,
  output csr_pkg::csr_write_t  write,
  output csr_pkg::status_t     status,
  output priv_pkg::priv_e      priv
);
  import csr_pkg::*;
  import priv_pkg::*;

  logic       mret_taken;
  logic       status_write;
  logic [1:0] new_mpp;

  // Trap beats mret
  assign mret_taken = mret && !trap_req.take;

  // Trap and mret both suppress the CSR write
  always_comb begin
    write.wr_en   = access.wr_en && !trap_req.take && !mret;
    write.addr    = access.addr;
    write.wr_data = access.wr_data;
  end

  assign status_write = write.wr_en && (write.addr == csr_mstatus);
  assign new_mpp      = write.wr_data[status_mpp +: 2];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      status <= '0;
      priv   <= priv_machine;
    end else if (trap_req.take) begin
      // All traps land in machine mode
      status.mie  <= 1'b0;
      status.mpie <= status.mie;
      status.mpp  <= priv;
      priv        <= priv_machine;
    end else if (mret_taken) begin
      status.mie  <= status.mpie;
      status.mpie <= 1'b1;
      status.mpp  <= priv_user;
      // MPP only ever holds a supported level
      priv        <= priv_e'(status.mpp);
    end else if (status_write) begin
      status.mie  <= write.wr_data[status_mie];
      status.mpie <= write.wr_data[status_mpie];
      // WARL, only user and machine are kept
      if (new_mpp == priv_user || new_mpp == priv_machine) begin
        status.mpp <= new_mpp;
      end
    end
  end

endmodule

/* logic/priv_pkg.sv */
// Privilege levels, trap cause codes and the trap request
// passed from trap control to the state holders
package priv_pkg;

  typedef enum logic [1:0] {
    priv_user    = 2'b00,
    priv_machine = 2'b11
  } priv_e;

  // Exception and interrupt codes as stored in mcause
  typedef enum logic [4:0] {
    cause_illegal_instr = 5'd2,
    cause_msi           = 5'd3,
    cause_mti           = 5'd7,
    cause_ecall_u       = 5'd8,
    cause_mei           = 5'd11
  } cause_e;

  // Machine ecall shares code 11 with MEI
  // The interrupt flag tells the two apart
  localparam cause_e cause_ecall_m = cause_mei;

  typedef struct packed {
    logic   take;
    logic   interrupt;
    cause_e code;
    logic   capture_tval;
  } trap_req_t;

endpackage

/* logic/trap_control.sv */
`timescale 1ns/1ps
// Qualifies interrupts and exceptions, picks the highest priority one
// and computes its cause and the direct or vectored trap address
module trap_control (
  input  csr_pkg::irq_t       enable,
  input  csr_pkg::irq_t       pending,
  input  csr_pkg::status_t    status,
  input  priv_pkg::priv_e     priv,
  input  csr_pkg::csr_data_t  mtvec,
  input  logic                illegal_instruction,
  input  logic                ecall,
  output priv_pkg::trap_req_t trap_req,
  output logic                trap,
  output csr_pkg::csr_data_t  trap_addr
);
  import csr_pkg::*;
  import priv_pkg::*;

  logic      user_mode;
  logic      trap_allowed;
  irq_t      active;
  logic      take_illegal;
  logic      take_ecall_u;
  logic      take_ecall_m;
  csr_data_t base;
  csr_data_t vector_offset;

  assign user_mode = (priv == priv_user);

  // User mode always takes machine traps, machine mode needs MIE
  assign trap_allowed = user_mode || status.mie;

  assign active = enable & pending & {3{trap_allowed}};

  assign take_illegal = illegal_instruction && trap_allowed;
  assign take_ecall_u = ecall && user_mode;
  assign take_ecall_m = ecall && !user_mode && status.mie;

  // Interrupts first, then synchronous exceptions
  always_comb begin
    trap_req      = '0;
    trap_req.code = cause_illegal_instr;
    if (active.external) begin
      trap_req.take      = 1'b1;
      trap_req.interrupt = 1'b1;
      trap_req.code      = cause_mei;
    end else if (active.timer) begin
      trap_req.take      = 1'b1;
      trap_req.interrupt = 1'b1;
      trap_req.code      = cause_mti;
    end else if (active.software) begin
      trap_req.take      = 1'b1;
      trap_req.interrupt = 1'b1;
      trap_req.code      = cause_msi;
    end else if (take_illegal) begin
      trap_req.take         = 1'b1;
      trap_req.code         = cause_illegal_instr;
      trap_req.capture_tval = 1'b1;
    end else if (take_ecall_u) begin
      trap_req.take = 1'b1;
      trap_req.code = cause_ecall_u;
    end else if (take_ecall_m) begin
      trap_req.take = 1'b1;
      trap_req.code = cause_ecall_m;
    end
  end

  assign trap = trap_req.take;

  // Mode bits of mtvec are not part of the address
  assign base          = {mtvec[xlen-1:2], 2'b00};
  assign vector_offset = {{(xlen - 7){1'b0}}, trap_req.code, 2'b00};

  // Vectored mode only applies to interrupts
  assign trap_addr = (mtvec[0] && trap_req.interrupt) ? base + vector_offset : base;

endmodule

/* sim/csr_unit_properties.sv */
`timescale 1ns/1ps
// Concurrent checks on the CSR unit outputs
module csr_unit_properties (
  input logic                 clock,
  input logic                 reset,
  input csr_pkg::csr_access_t access,
  input logic                 trap,
  input csr_pkg::csr_data_t   trap_addr,
  input logic                 addr_exception,
  input priv_pkg::priv_e      privilege_mode
);
  import priv_pkg::*;

  logic known_addr;

  // mstatus, misa, mie, mtvec and mscratch up to mip
  assign known_addr = access.addr inside {12'h300, 12'h301, 12'h304, 12'h305,
                                          [12'h340:12'h344]};

  trap_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    trap_addr[1:0] == 2'b00)
    else $error("trap address is not word aligned");

  unknown_address: assert property (@(posedge clock) disable iff (reset)
    addr_exception == !known_addr)
    else $error("address exception does not match the CSR map");

  machine_after_trap: assert property (@(posedge clock) disable iff (reset)
    trap |=> privilege_mode == priv_machine)
    else $error("trap did not enter machine mode");

endmodule

bind csr_unit csr_unit_properties i_properties (.*);

/* sim/csr_unit_tb.sv */
`timescale 1ns/1ps
// Directed testbench for the machine-mode CSR unit
// Covers reset values, WARL writes, traps, mret and interrupts
module csr_unit_tb;
  import csr_pkg::*;
  import priv_pkg::*;

  // The directed tests need under a hundred cycles
  localparam int max_cycles = 400;

  logic        clock;
  logic        reset;
  csr_access_t access;
  logic        mret;
  logic        illegal_instruction;
  logic        ecall;
  csr_data_t   pc;
  logic [31:0] instruction;
  logic        external_interrupt;
  logic        mem_msip;
  logic [63:0] mem_mtime;
  logic [63:0] mem_mtimecmp;
  csr_data_t   rd_data;
  logic        addr_exception;
  csr_data_t   mepc;
  csr_data_t   trap_addr;
  logic        trap;
  priv_e       privilege_mode;

  logic [31:0] lfsr_state = 32'h8e80_43be;
  int          cycles = 0;

  csr_unit i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic random_word(output logic [31:0] value);
    for (int i = 0; i < 32; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #10;
  endtask

  // Falling edge, long after the inputs have settled
  task automatic settle();
    @(negedge clock);
  endtask

  task automatic write_csr(csr_addr_t number, csr_data_t data);
    access = '{wr_en: 1'b1, addr: number, wr_data: data};
    next_cycle();
    access.wr_en = 1'b0;
  endtask

  task automatic expect_csr(string name, csr_addr_t number, csr_data_t expected);
    access = '{wr_en: 1'b0, addr: number, wr_data: '0};
    settle();
    compare(name, expected, rd_data);
    next_cycle();
  endtask

  task automatic pulse_mret();
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;
  endtask

  task automatic reset_values();
    compare("reset privilege", 32'(priv_machine), 32'(privilege_mode));
    expect_csr("reset misa", csr_misa, 32'h4010_0100);
    expect_csr("reset mstatus", csr_mstatus, '0);
    expect_csr("reset mie", csr_mie, '0);
    expect_csr("reset mtvec", csr_mtvec, '0);
    expect_csr("reset mcause", csr_mcause, '0);
    expect_csr("reset mip", csr_mip, '0);
    access.addr = 12'h100;
    settle();
    compare("unknown address", 32'd1, 32'(addr_exception));
    next_cycle();
  endtask

  task automatic write_read_back();
    logic [31:0] data;
    random_word(data);
    write_csr(csr_mscratch, data);
    expect_csr("mscratch", csr_mscratch, data);
    random_word(data);
    write_csr(csr_mtvec, data);
    expect_csr("mtvec", csr_mtvec, data & ~32'h2);
    random_word(data);
    write_csr(csr_mepc, data);
    expect_csr("mepc", csr_mepc, data & ~32'h3);
    random_word(data);
    write_csr(csr_mie, data);
    expect_csr("mie", csr_mie, data & 32'h888);
    write_csr(csr_mcause, 32'h5);
    expect_csr("illegal mcause", csr_mcause, '0);
    write_csr(csr_mcause, 32'h8000_0007);
    expect_csr("legal mcause", csr_mcause, 32'h8000_0007);
    write_csr(csr_mstatus, 32'h1800);
    expect_csr("mstatus mpp 11", csr_mstatus, 32'h1800);
    // MPP of 01 is not a kept level
    write_csr(csr_mstatus, 32'h0888);
    expect_csr("mstatus mpp 01", csr_mstatus, 32'h1888);
  endtask

  task automatic machine_ecall();
    logic [31:0] data;
    random_word(data);
    write_csr(csr_mie, '0);
    write_csr(csr_mscratch, 32'h1234_5678);
    write_csr(csr_mtvec, 32'h1000);
    write_csr(csr_mstatus, 32'h8);
    pc     = 32'h0000_4a10;
    ecall  = 1'b1;
    access = '{wr_en: 1'b1, addr: csr_mscratch, wr_data: data};
    settle();
    compare("machine ecall trap", 32'd1, 32'(trap));
    compare("machine ecall address", 32'h1000, trap_addr);
    next_cycle();
    ecall        = 1'b0;
    access.wr_en = 1'b0;
    expect_csr("machine ecall mcause", csr_mcause, 32'd11);
    compare("machine ecall mepc", pc, mepc);
    expect_csr("machine ecall mstatus", csr_mstatus, 32'h1880);
    expect_csr("write during trap", csr_mscratch, 32'h1234_5678);
  endtask

  task automatic mret_return();
    logic [31:0] word;
    write_csr(csr_mstatus, '0);
    pulse_mret();
    expect_csr("mret mstatus", csr_mstatus, 32'h80);
    compare("mret privilege", 32'(priv_user), 32'(privilege_mode));
    pc    = 32'h0000_5b20;
    ecall = 1'b1;
    settle();
    compare("user ecall trap", 32'd1, 32'(trap));
    next_cycle();
    ecall = 1'b0;
    expect_csr("user ecall mcause", csr_mcause, 32'd8);
    pulse_mret();
    random_word(word);
    instruction         = word;
    illegal_instruction = 1'b1;
    settle();
    compare("illegal trap", 32'd1, 32'(trap));
    next_cycle();
    illegal_instruction = 1'b0;
    expect_csr("illegal mcause", csr_mcause, 32'd2);
    expect_csr("illegal mtval", csr_mtval, word);
  endtask

  task automatic user_interrupts();
    write_csr(csr_mtvec, 32'h2001);
    write_csr(csr_mie, 32'h888);
    pulse_mret();
    compare("interrupt privilege", 32'(priv_user), 32'(privilege_mode));
    external_interrupt = 1'b1;
    mem_mtime          = 64'd10;
    mem_mtimecmp       = 64'd5;
    settle();
    compare("external trap", 32'd1, 32'(trap));
    compare("external address", 32'h202C, trap_addr);
    next_cycle();
    external_interrupt = 1'b0;
    expect_csr("external mcause", csr_mcause, 32'h8000_000B);
    // Timer still pending, machine mode with MIE clear
    settle();
    compare("masked timer", 32'd0, 32'(trap));
    next_cycle();
    pulse_mret();
    settle();
    compare("timer trap", 32'd1, 32'(trap));
    compare("timer address", 32'h201C, trap_addr);
    next_cycle();
    mem_mtime = '0;
  endtask

  initial begin
    reset               = 1'b1;
    access              = '0;
    mret                = 1'b0;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    pc                  = '0;
    instruction         = '0;
    external_interrupt  = 1'b0;
    mem_msip            = 1'b0;
    mem_mtime           = '0;
    mem_mtimecmp        = '1;
    repeat (8) @(posedge clock);
    #10;
    reset = 1'b0;
    reset_values();
    write_read_back();
    machine_ecall();
    mret_return();
    user_interrupts();
    $display("All tests passed!");
    $finish;
  end

endmodule
